/* Makefile */
TOP = tb_i2c_master

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "all tests passed"

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)
	verilator --lint-only -f files.f --top-module i2c_master_top \
		verilog/i2c_pkg.sv verilog/i2c_mem_if.sv verilog/i2c_conf_mem.sv \
		verilog/i2c_bus_regs.sv verilog/i2c_master_fsm.sv verilog/i2c_master_top.sv

clean:
	rm -rf obj_dir

/* dv/i2c_slave_model.sv */
// behavioral I2C slave for the master testbench
// start/stop detect, address match, write capture, read data out
`timescale 1ns/1ps
`default_nettype none

`include "i2c_macros.svh"

module i2c_slave_model #(
    parameter logic [6:0] ADDR = 7'h2A
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  scl,
    input  wire  sda,
    output logic sda_low
);

    logic [7:0] wr_data [64];              // bytes clocked in after the address
    int         wr_count;
    logic [7:0] rd_data [`I2C_MEM_BYTES];  // filled by the testbench
    logic       rd_ack [`I2C_MEM_BYTES];   // master ack per read byte
    int         rd_idx;
    logic       scl_q, sda_q;
    logic       active, addr_done, matched, rw, sending, nacked;
    logic [3:0] slot;                      // 0..7 bits, 8 ack, 15 before first bit
    logic [7:0] shift, cur;

    // lines sampled on the clock, edges found against last sample
    always @(posedge clk) begin
        if (rst) begin
            active   = 1'b0;
            wr_count = 0;
            rd_idx   = 0;
            scl_q    = 1'b1;
            sda_q    = 1'b1;
            sda_low <= 1'b0;
        end else begin
            if (scl && scl_q && sda_q && !sda) begin  // start
                active    = 1'b1;
                slot      = 4'd15;
                addr_done = 1'b0;
                matched   = 1'b0;
                sending   = 1'b0;
                nacked    = 1'b0;
                sda_low  <= 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin  // stop
                active   = 1'b0;
                sda_low <= 1'b0;
            end else if (active && scl && !scl_q) begin
                if (slot < 4'd8 && !sending)
                    shift = {shift[6:0], sda};
                else if (slot == 4'd8 && sending) begin
                    rd_ack[rd_idx-1] = !sda;
                    nacked           = sda;
                end
            end else if (active && !scl && scl_q) begin
                slot = (slot >= 4'd8) ? 4'd0 : slot + 4'd1;
                if (slot == 4'd8) begin
                    if (sending)
                        sda_low <= 1'b0;  // master acks this slot
                    else if (!addr_done) begin
                        addr_done = 1'b1;
                        matched   = (shift[7:1] == ADDR);
                        rw        = shift[0];
                        sda_low  <= matched;
                    end else begin
                        wr_data[wr_count] = shift;
                        wr_count          = wr_count + 1;
                        sda_low          <= matched;  // ack only our own address
                    end
                end else if (slot == 4'd0) begin
                    sending = addr_done && matched && rw && !nacked;
                    if (sending) begin
                        cur     = rd_data[rd_idx];
                        rd_idx  = rd_idx + 1;
                        sda_low <= ~cur[7];
                    end else
                        sda_low <= 1'b0;
                end else if (sending)
                    sda_low <= ~cur[3'd7 - slot[2:0]];
                else
                    sda_low <= 1'b0;
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

`default_nettype wire

/* dv/tb_i2c_master.sv */
// testbench for the I2C master
// clock, reset, bus tasks, xorshift stimulus, slave model and checks
`timescale 1ns/1ps
`default_nettype none

`include "i2c_macros.svh"

module tb_i2c_master;

    logic        I2C_CLK;
    logic        RST;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_rd;
    logic        bus_wr;
    logic        slave_rst;
    wire  [7:0]  bus_data_out;
    wire         scl_low, sda_low, slave_sda_low, scl_line, sda_line;
    logic [31:0] rng;
    logic [7:0]  exp_data [`I2C_MEM_BYTES];
    logic [7:0]  rdata;
    logic [7:0]  b;
    int          size;
    int          n;

    // wired-AND of the open-drain drivers
    assign scl_line = ~scl_low;
    assign sda_line = ~sda_low & ~slave_sda_low;

    i2c_master_top UUT (
        .I2C_CLK      (I2C_CLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .bus_data_out (bus_data_out),
        .scl_low      (scl_low),
        .sda_low      (sda_low),
        .sda_in       (sda_line)
    );

    i2c_slave_model slave (
        .clk     (I2C_CLK),
        .rst     (slave_rst),
        .scl     (scl_line),
        .sda     (sda_line),
        .sda_low (slave_sda_low)
    );

    initial begin
        I2C_CLK = 1'b0;
        forever #50 I2C_CLK = ~I2C_CLK;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_byte(output logic [7:0] v);
        rng = xorshift(rng);
        v   = rng[7:0];
    endtask

    task automatic check(input logic [7:0] actual, input logic [7:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("ERROR %0t: %s got %h expected %h", $time, msg, actual, expected);
            $display("tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge I2C_CLK);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge I2C_CLK);
        bus_wr      <= 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge I2C_CLK);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        @(posedge I2C_CLK);
        bus_rd  <= 1'b0;
        @(negedge I2C_CLK);  // data valid one cycle after the strobe
        data = bus_data_out;
    endtask

    task automatic run_transfer(input logic [7:0] slave_byte, input int len);
        @(posedge I2C_CLK);
        slave_rst <= 1'b1;
        @(posedge I2C_CLK);
        slave_rst <= 1'b0;
        bus_write(`I2C_ADDR_SLAVE, slave_byte);
        bus_write(`I2C_ADDR_SIZE_LO, 8'(len));
        bus_write(`I2C_ADDR_SIZE_HI, 8'h00);
        bus_write(`I2C_ADDR_START, 8'h00);
    endtask

    task automatic wait_done();
        int          cnt;
        logic [7:0]  st;
        cnt = 0;
        st  = 8'h00;
        while (!st[0] && cnt < 20000) begin
            bus_read(`I2C_ADDR_START, st);
            cnt = cnt + 1;
        end
        if (!st[0]) begin
            $display("transaction did not finish");
            $display("tests failed");
            $fatal(1, "timeout");
        end
    endtask

    task automatic fill_buffer(input int len);
        for (int i = 0; i < len; i++) begin
            next_byte(exp_data[i]);
            bus_write(`I2C_ADDR_MEM_BASE + 16'(i), exp_data[i]);
        end
    endtask

    task automatic write_and_check(input int len);
        fill_buffer(len);
        run_transfer({7'h2A, 1'b0}, len);
        wait_done();
        bus_read(`I2C_ADDR_START, rdata);
        check(rdata, 8'h01, "status after write");
        check(8'(slave.wr_count), 8'(len), "bytes seen by slave");
        for (int i = 0; i < len; i++)
            check(slave.wr_data[i], exp_data[i], "written byte");
    endtask

    initial begin
        RST         = 1'b1;
        bus_add     = '0;
        bus_data_in = '0;
        bus_rd      = 1'b0;
        bus_wr      = 1'b0;
        slave_rst   = 1'b1;
        rng         = 32'd57;
        repeat (3) @(posedge I2C_CLK);
        RST       <= 1'b0;
        slave_rst <= 1'b0;

        // reset values and config registers
        bus_read(`I2C_ADDR_START, rdata);
        check(rdata, 8'h01, "status after reset");
        bus_read(`I2C_ADDR_RESET, rdata);
        check(rdata, `I2C_VERSION, "version");
        check({6'd0, scl_low, sda_low}, 8'h00, "lines after reset");
        for (int r = 2; r <= 4; r++) begin
            next_byte(b);
            bus_write(16'(r), b);
            bus_read(16'(r), rdata);
            check(rdata, b, "config register");
        end

        // buffer window
        fill_buffer(`I2C_MEM_BYTES);
        for (int i = 0; i < `I2C_MEM_BYTES; i++) begin
            bus_read(`I2C_ADDR_MEM_BASE + 16'(i), rdata);
            check(rdata, exp_data[i], "buffer readback");
        end

        // write transaction
        rng  = xorshift(rng);
        size = int'(rng[3:0]) + 1;
        write_and_check(size);

        // read transaction
        rng  = xorshift(rng);
        size = int'(rng[3:0]) + 1;
        for (int i = 0; i < size; i++) begin
            next_byte(exp_data[i]);
            slave.rd_data[i] = exp_data[i];
        end
        run_transfer({7'h2A, 1'b1}, size);
        wait_done();
        bus_read(`I2C_ADDR_START, rdata);
        check(rdata, 8'h01, "status after read");
        for (int i = 0; i < size; i++) begin
            bus_read(`I2C_ADDR_MEM_BASE + 16'(i), rdata);
            check(rdata, exp_data[i], "read byte");
            check({7'd0, slave.rd_ack[i]}, {7'd0, i != size - 1}, "master ack");
        end

        // wrong slave address
        run_transfer({7'h15, 1'b0}, 4);
        wait_done();
        bus_read(`I2C_ADDR_START, rdata);
        check(rdata, 8'h03, "status after nack");
        check(8'(slave.wr_count), 8'h00, "bytes seen on nack");

        // soft reset in the middle of a write
        fill_buffer(8);
        run_transfer({7'h2A, 1'b0}, 8);
        repeat (120) @(posedge I2C_CLK);
        bus_write(`I2C_ADDR_RESET, 8'h00);
        n = 0;
        @(negedge I2C_CLK);
        while ((scl_low || sda_low) && n < 8) begin
            @(negedge I2C_CLK);
            n = n + 1;
        end
        if (scl_low || sda_low) begin
            $display("bus lines not released after soft reset");
            $display("tests failed");
            $fatal(1, "lines held");
        end
        // a running engine would pull SCL low again within one bit
        repeat (8) begin
            @(negedge I2C_CLK);
            check({6'd0, scl_low, sda_low}, 8'h00, "lines after soft reset");
        end
        bus_read(`I2C_ADDR_START, rdata);
        check(rdata, 8'h01, "status after soft reset");
        write_and_check(5);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+verilog
verilog/i2c_pkg.sv
verilog/i2c_mem_if.sv
verilog/i2c_conf_mem.sv
verilog/i2c_bus_regs.sv
verilog/i2c_master_fsm.sv
verilog/i2c_master_top.sv
dv/i2c_slave_model.sv
dv/tb_i2c_master.sv

/* verilog/i2c_bus_regs.sv */
// host register file of the I2C master
// config registers, status flags, start and soft reset strobes,
// buffer window decode and registered read mux
`timescale 1ns/1ps
`default_nettype none

`include "i2c_macros.svh"

module i2c_bus_regs (
    input  logic                   I2C_CLK,
    input  logic                   RST,
    input  logic [`I2C_ABUS_W-1:0] bus_add,
    input  logic [7:0]             bus_data_in,
    input  logic                   bus_rd,
    input  logic                   bus_wr,
    output logic [7:0]             bus_data_out,
    output i2c_pkg::i2c_conf_t     conf,
    output logic                   start,
    output logic                   soft_rst,
    input  logic                   done_pulse,
    input  logic                   no_ack_pulse,
    i2c_mem_if.host                mem
);

    localparam logic [`I2C_ABUS_W-1:0] MEM_END =
        `I2C_ADDR_MEM_BASE + `I2C_ABUS_W'(`I2C_MEM_BYTES);

    i2c_pkg::i2c_status_t status;
    logic                 in_mem;
    logic                 rd_mem;     // last read went to the buffer
    logic [7:0]           reg_rdata;

    assign in_mem = (bus_add >= `I2C_ADDR_MEM_BASE) && (bus_add < MEM_END);

    assign mem.en    = in_mem && (bus_rd || bus_wr);
    assign mem.we    = bus_wr;
    assign mem.addr  = bus_add - `I2C_ADDR_MEM_BASE;
    assign mem.wdata = bus_data_in;

    always_ff @(posedge I2C_CLK) begin
        if (RST) begin
            conf     <= '0;
            start    <= 1'b0;
            soft_rst <= 1'b0;
            rd_mem   <= 1'b0;
        end else begin
            start    <= bus_wr && (bus_add == `I2C_ADDR_START);
            soft_rst <= bus_wr && (bus_add == `I2C_ADDR_RESET);
            rd_mem   <= bus_rd && in_mem;
            if (bus_wr && bus_add == `I2C_ADDR_SLAVE)
                conf.slave <= bus_data_in;
            if (bus_wr && bus_add == `I2C_ADDR_SIZE_LO)
                conf.size[7:0] <= bus_data_in;
            if (bus_wr && bus_add == `I2C_ADDR_SIZE_HI)
                conf.size[15:8] <= bus_data_in;
        end
    end

    // done/no_ack flags, start clears them and the engine sets them
    always_ff @(posedge I2C_CLK) begin
        if (RST || soft_rst) begin
            status.done   <= 1'b1;
            status.no_ack <= 1'b0;
        end else if (start) begin
            status <= '0;
        end else begin
            if (done_pulse)
                status.done <= 1'b1;
            if (no_ack_pulse)
                status.no_ack <= 1'b1;
        end
    end

    always_ff @(posedge I2C_CLK) begin
        if (bus_rd) begin
            case (bus_add)
                `I2C_ADDR_RESET:   reg_rdata <= `I2C_VERSION;
                `I2C_ADDR_START:   reg_rdata <= {6'd0, status};
                `I2C_ADDR_SLAVE:   reg_rdata <= conf.slave;
                `I2C_ADDR_SIZE_LO: reg_rdata <= conf.size[7:0];
                `I2C_ADDR_SIZE_HI: reg_rdata <= conf.size[15:8];
                default:           reg_rdata <= 8'h00;
            endcase
        end
    end

    assign bus_data_out = rd_mem ? mem.rdata : reg_rdata;

    // the engine reports completion only once per start
    a_single_done: assert property (@(posedge I2C_CLK) disable iff (RST)
        done_pulse |-> !status.done);

endmodule

`default_nettype wire

/* verilog/i2c_conf_mem.sv */
// dual-port transfer buffer
// bus port and engine port, engine write wins on a collision
`timescale 1ns/1ps
`default_nettype none

`include "i2c_macros.svh"

module i2c_conf_mem (
    input logic    I2C_CLK,
    i2c_mem_if.mem bus_port,
    i2c_mem_if.mem eng_port
);

    localparam int AW = $clog2(`I2C_MEM_BYTES);

    logic [7:0] mem_q [`I2C_MEM_BYTES];

    // both ports in one block, the engine write comes last
    always_ff @(posedge I2C_CLK) begin
        if (bus_port.en) begin
            if (bus_port.we)
                mem_q[bus_port.addr[AW-1:0]] <= bus_port.wdata;
            bus_port.rdata <= mem_q[bus_port.addr[AW-1:0]];
        end
        if (eng_port.en) begin
            if (eng_port.we)
                mem_q[eng_port.addr[AW-1:0]] <= eng_port.wdata;
            eng_port.rdata <= mem_q[eng_port.addr[AW-1:0]];
        end
    end

    // both hosts must stay inside the buffer, the engine relies on conf.size
    a_addr_range: assert property (@(posedge I2C_CLK)
        (bus_port.en |-> bus_port.addr < `I2C_ABUS_W'(`I2C_MEM_BYTES)) and
        (eng_port.en |-> eng_port.addr < `I2C_ABUS_W'(`I2C_MEM_BYTES)));

endmodule

`default_nettype wire

/* verilog/i2c_macros.svh */
// register map, buffer depth, version and bus widths
// shared by the I2C master RTL and its testbench
`ifndef I2C_MACROS_SVH
`define I2C_MACROS_SVH

// bus address width, register addresses use the same width
`define I2C_ABUS_W 16

// register map
`define I2C_ADDR_RESET    16'd0  // write: soft reset, read: version
`define I2C_ADDR_START    16'd1  // write: start, read: status
`define I2C_ADDR_SLAVE    16'd2
`define I2C_ADDR_SIZE_LO  16'd3
`define I2C_ADDR_SIZE_HI  16'd4
`define I2C_ADDR_MEM_BASE 16'd8

`define I2C_MEM_BYTES 16
`define I2C_VERSION   8'h01

// clock cycles per SCL bit
`define I2C_PHASES 4

`endif

/* verilog/i2c_master_fsm.sv */
// I2C transaction engine
// phase divider, start latch, bit/byte counters, state machine,
// tx/rx shifters and open-drain SCL/SDA drive-low outputs
`timescale 1ns/1ps
`default_nettype none

`include "i2c_macros.svh"

module i2c_master_fsm (
    input  logic                I2C_CLK,
    input  logic                RST,
    input  i2c_pkg::i2c_conf_t  conf,
    input  logic                start,
    input  logic                soft_rst,
    input  logic                sda_in,
    output logic                scl_low,
    output logic                sda_low,
    output logic                done_pulse,
    output logic                no_ack_pulse,
    output i2c_pkg::i2c_state_e state,
    i2c_mem_if.host             mem
);

    localparam int PW = $clog2(`I2C_PHASES);
    localparam logic [PW-1:0] PH_SDA  = PW'(0);  // SDA update
    localparam logic [PW-1:0] PH_REL  = PW'(1);  // SCL release, ack sample
    localparam logic [PW-1:0] PH_MEM  = PW'(2);  // buffer access
    localparam logic [PW-1:0] PH_LAST = PW'(`I2C_PHASES - 1);

    i2c_pkg::i2c_state_e next_state;
    logic [PW-1:0]       phase;
    logic                start_req;
    logic [2:0]          bit_cnt;
    logic [15:0]         byte_cnt;
    logic [7:0]          tx_shift;
    logic [7:0]          rx_shift;
    logic                ack_bit;     // SDA seen in an ack slot, 1 = nack
    logic                shifting;
    logic                byte_end;
    logic                last_byte;
    logic                hold_scl;
    logic                sda_drv;

    assign shifting  = state inside {i2c_pkg::st_addr, i2c_pkg::st_data_w, i2c_pkg::st_data_r};
    assign byte_end  = (state inside {i2c_pkg::st_data_w, i2c_pkg::st_data_r}) &&
                       (bit_cnt == 3'd7);
    assign last_byte = (byte_cnt == conf.size);

    always_comb begin
        next_state = state;
        case (state)
            i2c_pkg::st_idle:   if (start_req) next_state = i2c_pkg::st_start;
            i2c_pkg::st_start:  next_state = i2c_pkg::st_addr;
            i2c_pkg::st_addr:   if (bit_cnt == 3'd7) next_state = i2c_pkg::st_aack;
            i2c_pkg::st_aack:
                if (ack_bit)
                    next_state = i2c_pkg::st_idle;
                else
                    next_state = conf.slave[0] ? i2c_pkg::st_data_r : i2c_pkg::st_data_w;
            i2c_pkg::st_data_w: if (bit_cnt == 3'd7) next_state = i2c_pkg::st_dack_w;
            i2c_pkg::st_data_r: if (bit_cnt == 3'd7) next_state = i2c_pkg::st_dack_r;
            i2c_pkg::st_dack_w:
                if (ack_bit)
                    next_state = i2c_pkg::st_idle;
                else
                    next_state = last_byte ? i2c_pkg::st_stop : i2c_pkg::st_data_w;
            i2c_pkg::st_dack_r:
                next_state = last_byte ? i2c_pkg::st_stop : i2c_pkg::st_data_r;
            default:            next_state = i2c_pkg::st_idle;  // stop
        endcase
    end

    // SCL stays released around start, stop and idle
    assign hold_scl = !(state inside {i2c_pkg::st_idle, i2c_pkg::st_stop}) &&
                      (next_state != i2c_pkg::st_idle);

    always_comb begin
        case (state)
            i2c_pkg::st_start:  sda_drv = 1'b1;
            i2c_pkg::st_addr:   sda_drv = ~conf.slave[3'd7 - bit_cnt];
            i2c_pkg::st_data_w: sda_drv = ~tx_shift[7];
            i2c_pkg::st_dack_r: sda_drv = !last_byte;  // no ack on the last byte
            i2c_pkg::st_stop:   sda_drv = 1'b1;
            default:            sda_drv = 1'b0;
        endcase
    end

    always_ff @(posedge I2C_CLK) begin
        if (RST) begin
            phase     <= '0;
            state     <= i2c_pkg::st_idle;
            start_req <= 1'b0;
            bit_cnt   <= '0;
            scl_low   <= 1'b0;
            sda_low   <= 1'b0;
        end else begin
            phase <= phase + 1'b1;
            if (start && state == i2c_pkg::st_idle)
                start_req <= 1'b1;
            else if (state == i2c_pkg::st_start)
                start_req <= 1'b0;
            if (phase == PH_SDA)
                sda_low <= sda_drv;
            if (phase == PH_REL)
                scl_low <= 1'b0;
            if (phase == PH_LAST) begin
                state   <= next_state;
                scl_low <= hold_scl;
                bit_cnt <= shifting ? bit_cnt + 1'b1 : 3'd0;
            end
        end
    end

    always_ff @(posedge I2C_CLK) begin
        if (RST || state == i2c_pkg::st_idle)
            byte_cnt <= '0;
        else if (phase == PH_LAST && byte_end)
            byte_cnt <= byte_cnt + 1'b1;
    end

    always_ff @(posedge I2C_CLK) begin
        if (phase == PH_REL)
            ack_bit <= sda_in;
        if (phase == PH_LAST && state == i2c_pkg::st_data_r)
            rx_shift <= {rx_shift[6:0], sda_in};
        if (phase == PH_LAST && next_state == i2c_pkg::st_data_w &&
            state != i2c_pkg::st_data_w)
            tx_shift <= mem.rdata;  // prefetched in the ack slot
        else if (phase == PH_LAST && state == i2c_pkg::st_data_w)
            tx_shift <= {tx_shift[6:0], 1'b0};
    end

    // read next tx byte in aack/dack_w, store rx byte in dack_r
    assign mem.we    = (state == i2c_pkg::st_dack_r);
    assign mem.en    = (phase == PH_MEM) &&
                       (mem.we ||
                        (state == i2c_pkg::st_aack && !conf.slave[0]) ||
                        (state == i2c_pkg::st_dack_w && !last_byte));
    assign mem.addr  = mem.we ? byte_cnt - 16'd1 : byte_cnt;
    assign mem.wdata = rx_shift;

    assign no_ack_pulse = (phase == PH_LAST) && ack_bit &&
                          (state inside {i2c_pkg::st_aack, i2c_pkg::st_dack_w});
    assign done_pulse   = no_ack_pulse ||
                          (phase == PH_LAST && next_state == i2c_pkg::st_stop);

    a_idle_scl: assert property (@(posedge I2C_CLK) disable iff (RST)
        state == i2c_pkg::st_idle |-> !scl_low);

    a_sda_phase: assert property (@(posedge I2C_CLK) disable iff (RST)
        !$stable(sda_low) |-> $past(phase == PH_SDA || RST));

    // soft reset from the register side frees the bus right away
    a_soft_rst: assert property (@(posedge I2C_CLK)
        soft_rst |=> state == i2c_pkg::st_idle && !scl_low && !sda_low);

    a_size: assert property (@(posedge I2C_CLK) disable iff (RST)
        state == i2c_pkg::st_start |->
            conf.size != 16'd0 && conf.size <= 16'(`I2C_MEM_BYTES));

endmodule

`default_nettype wire

/* verilog/i2c_master_top.sv */
// I2C master top level
// register file, transfer buffer and engine on plain ports,
// SCL/SDA as drive-low outputs plus sampled SDA
`timescale 1ns/1ps
`default_nettype none

`include "i2c_macros.svh"

module i2c_master_top (
    input  logic                   I2C_CLK,
    input  logic                   RST,
    input  logic [`I2C_ABUS_W-1:0] bus_add,
    input  logic [7:0]             bus_data_in,
    input  logic                   bus_rd,
    input  logic                   bus_wr,
    output logic [7:0]             bus_data_out,
    output logic                   scl_low,
    output logic                   sda_low,
    input  logic                   sda_in
);

    i2c_pkg::i2c_conf_t conf;
    logic               start;
    logic               soft_rst;
    logic               eng_rst;
    logic               done_pulse;
    logic               no_ack_pulse;

    i2c_mem_if bus_mem_port ();
    i2c_mem_if eng_mem_port ();

    assign eng_rst = RST | soft_rst;  // soft reset only restarts the engine

    i2c_bus_regs u_regs (
        .I2C_CLK      (I2C_CLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .bus_data_out (bus_data_out),
        .conf         (conf),
        .start        (start),
        .soft_rst     (soft_rst),
        .done_pulse   (done_pulse),
        .no_ack_pulse (no_ack_pulse),
        .mem          (bus_mem_port.host)
    );

    i2c_conf_mem u_mem (
        .I2C_CLK  (I2C_CLK),
        .bus_port (bus_mem_port.mem),
        .eng_port (eng_mem_port.mem)
    );

    i2c_master_fsm u_fsm (
        .I2C_CLK      (I2C_CLK),
        .RST          (eng_rst),
        .conf         (conf),
        .start        (start),
        .soft_rst     (soft_rst),
        .sda_in       (sda_in),
        .scl_low      (scl_low),
        .sda_low      (sda_low),
        .done_pulse   (done_pulse),
        .no_ack_pulse (no_ack_pulse),
        .state        (),
        .mem          (eng_mem_port.host)
    );

endmodule

`default_nettype wire

/* verilog/i2c_mem_if.sv */
// one byte-wide port of the transfer buffer
// host side drives the request, mem side returns read data
`timescale 1ns/1ps
`default_nettype none

`include "i2c_macros.svh"

interface i2c_mem_if;

    logic                   en;
    logic                   we;
    logic [`I2C_ABUS_W-1:0] addr;   // byte index into the buffer
    logic [7:0]             wdata;
    logic [7:0]             rdata;  // valid the cycle after en

    modport host (output en, we, addr, wdata, input rdata);
    modport mem  (input en, we, addr, wdata, output rdata);

endinterface

`default_nettype wire

/* verilog/i2c_pkg.sv */
// shared types for the I2C master
// FSM state encoding, configuration and status words
`default_nettype none

package i2c_pkg;

    typedef enum logic [3:0] {
        st_idle   = 4'd0,
        st_start  = 4'd1,
        st_addr   = 4'd2,
        st_aack   = 4'd3,
        st_data_w = 4'd4,
        st_data_r = 4'd5,
        st_dack_w = 4'd6,
        st_dack_r = 4'd7,
        st_stop   = 4'd8
    } i2c_state_e;

    typedef struct packed {
        logic [7:0]  slave;  // 7-bit address, bit 0 set for read
        logic [15:0] size;   // bytes in the transfer
    } i2c_conf_t;

    typedef struct packed {
        logic no_ack;
        logic done;
    } i2c_status_t;

endpackage

`default_nettype wire
